// ==== byte_fifo.sv ====
`timescale 1ns/1ns

module byte_fifo #(
   parameter int FIFO_DEPTH = 8
) (
   input  logic          clk,
   input  logic          rst,
   byte_stream_if.sink   in,
   byte_stream_if.source out
);

   localparam int AW = $clog2(FIFO_DEPTH);

   hex_dump_pkg::data_byte_t data_mem [FIFO_DEPTH];
   logic                     last_mem [FIFO_DEPTH];
   logic [AW:0]              wr_ptr;   // extra bit tells full from empty
   logic [AW:0]              rd_ptr;
   logic                     full;
   logic                     empty;
   logic                     push;
   logic                     pop;

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign push  = in.valid && !full;
   assign pop   = out.valid && out.ready;

   assign in.ready  = !full;
   assign out.valid = !empty;
   assign out.data  = data_mem[rd_ptr[AW-1:0]];   // head stays put until popped
   assign out.last  = last_mem[rd_ptr[AW-1:0]];

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr[AW-1:0]] <= in.data;
         last_mem[wr_ptr[AW-1:0]] <= in.last;
      end
   end

endmodule

// ==== byte_stream_if.sv ====
`timescale 1ns/1ns

interface byte_stream_if;

   logic                     valid;
   logic                     ready;
   hex_dump_pkg::data_byte_t data;
   logic                     last;   // final byte of a dump

   modport source (
      output valid, data, last,
      input  ready
   );

   modport sink (
      input  valid, data, last,
      output ready
   );

endinterface

// ==== hex_dump.f ====
hex_dump_pkg.sv
byte_stream_if.sv
spi_flash_reader.sv
byte_fifo.sv
uart_hex_tx.sv
hex_dump.sv
hex_dump_checker.sv
hex_dump_tb.sv

// ==== hex_dump.sv ====
`timescale 1ns/1ns

module hex_dump #(
   parameter int SCK_HALF     = 2,
   parameter int FIFO_DEPTH   = 8,
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  hex_dump_pkg::flash_addr_t start_addr,
   input  hex_dump_pkg::byte_count_t byte_count,
   input  logic                      spi_miso,
   output logic                      uart_tx,
   output logic                      spi_sck,
   output logic                      spi_cs_n,
   output logic                      spi_mosi,
   output logic                      busy,
   output logic                      done
);

   logic busy_r;
   logic start_ok;

   byte_stream_if rd_to_fifo ();
   byte_stream_if fifo_to_tx ();

   // zero-length and overlapping requests are dropped
   assign start_ok = start && !busy && (byte_count != '0);
   assign busy     = busy_r && !done;   // low in the done cycle

   always_ff @(posedge clk) begin
      if (rst) begin
         busy_r <= 1'b0;
      end else if (start_ok) begin
         busy_r <= 1'b1;
      end else if (done) begin
         busy_r <= 1'b0;
      end
   end

   spi_flash_reader #(.SCK_HALF(SCK_HALF)) u_reader (
      .clk(clk), .rst(rst), .start(start_ok), .start_addr(start_addr),
      .byte_count(byte_count), .spi_sck(spi_sck), .spi_cs_n(spi_cs_n),
      .spi_mosi(spi_mosi), .spi_miso(spi_miso), .out(rd_to_fifo.source)
   );

   byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst(rst), .in(rd_to_fifo.sink), .out(fifo_to_tx.source)
   );

   uart_hex_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
      .clk(clk), .rst(rst), .in(fifo_to_tx.sink), .uart_tx(uart_tx), .done(done)
   );

endmodule

// ==== hex_dump_checker.sv ====
`timescale 1ns/1ns

module hex_dump_checker (
   input logic clk,
   input logic rst,
   input logic busy,
   input logic done,
   input logic spi_cs_n,
   input logic spi_sck,
   input logic uart_tx
);

   int fail_cnt = 0;   // failed assertions so far

   cs_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> spi_cs_n)
      else begin
         $error("spi_cs_n low while not busy");
         fail_cnt++;
      end

   sck_idle: assert property (@(posedge clk) disable iff (rst) spi_cs_n |-> !spi_sck)
      else begin
         $error("spi_sck high while deselected");
         fail_cnt++;
      end

   tx_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> uart_tx)
      else begin
         $error("uart_tx low while not busy");
         fail_cnt++;
      end

   done_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
      else begin
         $error("done without busy in the cycle before");
         fail_cnt++;
      end

endmodule

bind hex_dump hex_dump_checker u_checker (
   .clk(clk), .rst(rst), .busy(busy), .done(done),
   .spi_cs_n(spi_cs_n), .spi_sck(spi_sck), .uart_tx(uart_tx)
);

// ==== hex_dump_pkg.sv ====
package hex_dump_pkg;

   typedef logic [23:0] flash_addr_t;   // flash byte address
   typedef logic [15:0] byte_count_t;   // dump length in bytes
   typedef logic [7:0]  data_byte_t;    // data byte or ascii char

   localparam data_byte_t CMD_READ = 8'h03;   // serial flash read opcode

   typedef enum logic [2:0] {
      rd_idle,
      rd_command,
      rd_address,
      rd_data,
      rd_finish
   } reader_state_t;

   typedef enum logic [1:0] {
      tx_idle,
      tx_start_bit,
      tx_data_bits,
      tx_stop_bit
   } tx_state_t;

   // upper case ascii code of one hex digit
   function automatic data_byte_t hex_char(input logic [3:0] nibble);
      data_byte_t code;
      if (nibble < 4'd10) begin
         code = 8'h30 + {4'h0, nibble};   // '0'..'9'
      end else begin
         code = 8'h37 + {4'h0, nibble};   // 'A'..'F'
      end
      return code;
   endfunction

endpackage

// ==== hex_dump_stim.txt ====
# kind addr count checksum, all hex
# kind 1 single byte, 2 boundary, 3 back-pressure, 4 start while busy, 5 zero count
1 000123 0001 22
2 00fff8 0010 38
3 000200 0028 0c
4 001000 0004 46
5 000400 0000 00

// ==== hex_dump_tb.sv ====
`timescale 1ns/1ns

module hex_dump_tb;

   localparam int CPB = 16;

   logic clk, rst, start, spi_miso, uart_tx, spi_sck, spi_cs_n, spi_mosi, busy, done;
   logic [23:0] start_addr;
   logic [15:0] byte_count;
   logic [31:0] lfsr = 32'h22fcce77;
   logic [31:0] cmd_word;
   logic [7:0]  pend_hi, rx_char, flash_byte;
   logic        prev_sck, prev_cs, half_char;
   int unsigned cycles, limit, rise_cnt, fall_cnt, cmd_cnt, cs_rise_cnt, done_cnt, chars;
   int          err_cnt, test_cnt, ntests;
   logic [7:0]  rx_bytes [$];
   int          t_kind [16];
   logic [23:0] t_addr [16];
   logic [15:0] t_count [16];
   logic [7:0]  t_sum [16];

   hex_dump #(.SCK_HALF(2), .FIFO_DEPTH(8), .CLKS_PER_BIT(CPB)) UUT (
      .clk(clk), .rst(rst), .start(start), .start_addr(start_addr),
      .byte_count(byte_count), .spi_miso(spi_miso), .uart_tx(uart_tx),
      .spi_sck(spi_sck), .spi_cs_n(spi_cs_n), .spi_mosi(spi_mosi), .busy(busy), .done(done)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [7:0] model_byte(input logic [23:0] a);
      return a[23:16] ^ a[15:8] ^ a[7:0];
   endfunction

   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp) begin
         $display("Fail at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
         err_cnt++;
      end
   endtask

   // flash model samples mid clock where sck and mosi are settled
   always @(negedge clk) begin
      if (prev_cs && !spi_cs_n) begin
         rise_cnt = 0;
         fall_cnt = 0;
         cmd_cnt++;
      end
      if (!prev_cs && spi_cs_n) cs_rise_cnt++;
      if (!spi_cs_n && spi_sck && !prev_sck && rise_cnt < 32) begin
         cmd_word = {cmd_word[30:0], spi_mosi};
         rise_cnt++;
      end
      if (!spi_cs_n && !spi_sck && prev_sck) begin
         fall_cnt++;
         if (fall_cnt >= 32) begin   // data phase drives bit k of the stream
            flash_byte = model_byte(cmd_word[23:0] + 24'((fall_cnt - 32) / 8));
            spi_miso   = flash_byte[7 - (fall_cnt - 32) % 8];
         end
      end
      if (done) done_cnt++;
      prev_sck = spi_sck;
      prev_cs  = spi_cs_n;
   end

   // uart receiver turns hex char pairs back into bytes
   initial begin : uart_rx
      int nib;
      forever begin
         @(negedge clk);
         if (!rst && uart_tx == 1'b0) begin
            repeat (CPB / 2) @(negedge clk);
            for (int i = 0; i < 8; i++) begin
               repeat (CPB) @(negedge clk);
               rx_char[i] = uart_tx;
            end
            repeat (CPB) @(negedge clk);
            if (uart_tx !== 1'b1) begin
               $display("Stop bit missing at %0t ns", $time);
               err_cnt++;
            end
            if (rx_char >= "0" && rx_char <= "9") begin
               nib = rx_char - "0";
            end else if (rx_char >= "A" && rx_char <= "F") begin
               nib = rx_char - "A" + 10;
            end else begin
               nib = -1;
               $display("Received character %h is not an upper case hex digit", rx_char);
               err_cnt++;
            end
            chars++;
            if (half_char) rx_bytes.push_back({pend_hi[3:0], 4'(nib)});
            else pend_hi = 8'(nib);
            half_char = !half_char;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (limit != 0 && cycles > limit) begin
         $display("Timeout: the dump did not finish within %0d cycles", limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic pulse_start(input logic [23:0] a, input logic [15:0] n);
      @(posedge clk);
      #1 start = 1'b1;
      start_addr = a;
      byte_count = n;
      @(posedge clk);
      #1 start = 1'b0;
   endtask

   initial begin : main
      int fd, gap, e0, cmd0, cs0, done0;
      logic [7:0] sum;
      string line;
      {start, spi_miso, start_addr, byte_count, half_char, cmd_word} = '0;
      {prev_sck, prev_cs} = 2'b01;
      {cycles, limit, cmd_cnt, cs_rise_cnt, done_cnt, chars, err_cnt, ntests} = '0;
      rst = 1'b1;
      fd = $fopen("hex_dump_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open hex_dump_stim.txt");
         err_cnt++;
      end else begin
         while ($fgets(line, fd)) begin
            if (line.len() > 1 && line[0] != "#" &&
                $sscanf(line, "%h %h %h %h", t_kind[ntests], t_addr[ntests],
                        t_count[ntests], t_sum[ntests]) == 4) begin
               limit += t_count[ntests] * 20 * CPB;
               ntests++;
            end
         end
         $fclose(fd);
      end
      limit += 2000;
      repeat (3) @(posedge clk);
      #1 rst = 1'b0;
      @(negedge clk);
      check_value({busy, done, spi_sck, spi_cs_n, uart_tx}, 5'b00011, "reset state");
      for (test_cnt = 0; test_cnt < ntests; test_cnt++) begin
         gap = 0;
         repeat (4) gap = {gap[2:0], lfsr_bit()};
         repeat (gap) @(posedge clk);
         {e0, cmd0, cs0, done0} = {err_cnt, cmd_cnt, cs_rise_cnt, done_cnt};
         rx_bytes.delete();
         chars = 0;
         pulse_start(t_addr[test_cnt], t_count[test_cnt]);
         if (t_kind[test_cnt] == 5) begin
            repeat (60) begin
               @(negedge clk);
               check_value(busy, 0, "busy after zero-count start");
            end
         end else begin
            check_value(busy, 1, "busy after start");
            if (t_kind[test_cnt] == 4) begin
               repeat (100) @(posedge clk);
               pulse_start(t_addr[test_cnt] + 24'h40, 16'd3);
            end
            do @(negedge clk); while (!done);
            check_value(busy, 0, "busy in the done cycle");
            repeat (2) @(negedge clk);
            check_value(cmd_word, {8'h03, t_addr[test_cnt]}, "command and address");
         end
         sum = '0;
         foreach (rx_bytes[i]) begin
            sum += rx_bytes[i];
            check_value(rx_bytes[i], model_byte(t_addr[test_cnt] + 24'(i)), "byte value");
         end
         check_value(sum, t_sum[test_cnt], "checksum");
         check_value(chars, 2 * t_count[test_cnt], "character count");
         check_value(cmd_cnt - cmd0, t_count[test_cnt] != 0, "commands issued");
         check_value(cs_rise_cnt - cs0, t_count[test_cnt] != 0, "chip select releases");
         check_value(done_cnt - done0, t_count[test_cnt] != 0, "done pulses");
         $display("test %0d kind %0d: %s", test_cnt, t_kind[test_cnt],
                  (err_cnt == e0) ? "ok" : "errors");
      end
      err_cnt += UUT.u_checker.fail_cnt;   // protocol assertion failures
      $display("%0d tests, %0d errors", ntests, err_cnt);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// ==== spi_flash_reader.sv ====
`timescale 1ns/1ns

module spi_flash_reader #(
   parameter int SCK_HALF = 2
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      start,
   input  hex_dump_pkg::flash_addr_t start_addr,
   input  hex_dump_pkg::byte_count_t byte_count,
   output logic                      spi_sck,
   output logic                      spi_cs_n,
   output logic                      spi_mosi,
   input  logic                      spi_miso,
   byte_stream_if.source             out
);

   localparam int HW = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
   localparam logic [HW-1:0] HALF_MAX = HW'(SCK_HALF - 1);

   hex_dump_pkg::reader_state_t state;
   logic [HW-1:0]               half_cnt;
   logic [4:0]                  bit_cnt;    // sck cycles within phase
   logic [31:0]                 tx_sreg;    // opcode then address
   hex_dump_pkg::data_byte_t    rx_sreg;
   hex_dump_pkg::byte_count_t   bytes_left;
   logic                        shifting;
   logic                        sck_run;
   logic                        sck_tick;
   logic                        rise_tick;
   logic                        fall_tick;
   logic                        byte_done;

   assign shifting = (state == hex_dump_pkg::rd_command) ||
                     (state == hex_dump_pkg::rd_address) ||
                     (state == hex_dump_pkg::rd_data);

   // sck parks low while a byte waits for the fifo
   assign sck_run   = shifting && !(out.valid && !out.ready);
   assign sck_tick  = sck_run && (half_cnt == HALF_MAX);
   assign rise_tick = sck_tick && !spi_sck;
   assign fall_tick = sck_tick && spi_sck;
   assign byte_done = fall_tick && (state == hex_dump_pkg::rd_data) && (bit_cnt[2:0] == 3'd7);

   assign spi_mosi = tx_sreg[31];   // ones once the address is out

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= hex_dump_pkg::rd_idle;
         half_cnt   <= '0;
         bit_cnt    <= '0;
         tx_sreg    <= '1;
         bytes_left <= '0;
         spi_sck    <= 1'b0;
         spi_cs_n   <= 1'b1;
         out.valid  <= 1'b0;
         out.last   <= 1'b0;
      end else begin
         if (out.valid && out.ready) begin
            out.valid <= 1'b0;
         end
         if (sck_run) begin
            half_cnt <= sck_tick ? '0 : half_cnt + 1'b1;
         end
         if (sck_tick) begin
            spi_sck <= ~spi_sck;
         end
         if (fall_tick) begin
            bit_cnt <= bit_cnt + 1'b1;   // wraps to 0 entering data
            tx_sreg <= {tx_sreg[30:0], 1'b1};
         end
         if (byte_done) begin
            out.valid  <= 1'b1;
            out.last   <= (bytes_left == 16'd1);
            bytes_left <= bytes_left - 1'b1;
         end

         case (state)
            hex_dump_pkg::rd_idle: begin
               if (start) begin
                  tx_sreg    <= {hex_dump_pkg::CMD_READ, start_addr};
                  bytes_left <= byte_count;
                  half_cnt   <= '0;
                  bit_cnt    <= '0;
                  spi_cs_n   <= 1'b0;
                  state      <= hex_dump_pkg::rd_command;
               end
            end
            hex_dump_pkg::rd_command: begin
               if (fall_tick && bit_cnt == 5'd7) begin
                  state <= hex_dump_pkg::rd_address;
               end
            end
            hex_dump_pkg::rd_address: begin
               if (fall_tick && bit_cnt == 5'd31) begin
                  state <= hex_dump_pkg::rd_data;
               end
            end
            hex_dump_pkg::rd_data: begin
               if (byte_done && bytes_left == 16'd1) begin
                  state <= hex_dump_pkg::rd_finish;
               end
            end
            hex_dump_pkg::rd_finish: begin
               if (out.valid && out.ready) begin   // last byte taken
                  spi_cs_n <= 1'b1;
                  state    <= hex_dump_pkg::rd_idle;
               end
            end
            default: state <= hex_dump_pkg::rd_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rise_tick && state == hex_dump_pkg::rd_data) begin
         rx_sreg <= {rx_sreg[6:0], spi_miso};   // msb first
      end
      if (byte_done) begin
         out.data <= rx_sreg;
      end
   end

endmodule

// ==== uart_hex_tx.sv ====
`timescale 1ns/1ns

module uart_hex_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic        clk,
   input  logic        rst,
   byte_stream_if.sink in,
   output logic        uart_tx,
   output logic        done
);

   localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
   localparam logic [CW-1:0] BIT_MAX = CW'(CLKS_PER_BIT - 1);

   hex_dump_pkg::tx_state_t  state;
   logic [CW-1:0]            bit_clk;     // clocks within one bit
   logic [2:0]               bit_idx;
   logic                     low_nib;     // second char of the byte
   hex_dump_pkg::data_byte_t char_sreg;
   logic [3:0]               low_nibble;
   logic                     byte_last;
   logic                     bit_end;
   logic                     char_end;
   logic                     load;

   assign bit_end  = (bit_clk == BIT_MAX);
   assign char_end = (state == hex_dump_pkg::tx_stop_bit) && bit_end;

   // next byte may follow the stop bit directly
   assign load     = (state == hex_dump_pkg::tx_idle) || (char_end && low_nib);
   assign in.ready = load;

   always_comb begin
      case (state)
         hex_dump_pkg::tx_start_bit: uart_tx = 1'b0;
         hex_dump_pkg::tx_data_bits: uart_tx = char_sreg[0];   // lsb first
         default:                    uart_tx = 1'b1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= hex_dump_pkg::tx_idle;
         bit_clk <= '0;
         bit_idx <= '0;
         low_nib <= 1'b0;
         done    <= 1'b0;
      end else begin
         done <= 1'b0;
         if (state != hex_dump_pkg::tx_idle) begin
            bit_clk <= bit_end ? '0 : bit_clk + 1'b1;
         end
         case (state)
            hex_dump_pkg::tx_idle: begin
               if (in.valid) begin
                  bit_clk <= '0;
                  low_nib <= 1'b0;
                  state   <= hex_dump_pkg::tx_start_bit;
               end
            end
            hex_dump_pkg::tx_start_bit: begin
               if (bit_end) begin
                  bit_idx <= '0;
                  state   <= hex_dump_pkg::tx_data_bits;
               end
            end
            hex_dump_pkg::tx_data_bits: begin
               if (bit_end) begin
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= hex_dump_pkg::tx_stop_bit;
                  end
               end
            end
            hex_dump_pkg::tx_stop_bit: begin
               if (bit_end) begin
                  if (!low_nib) begin
                     low_nib <= 1'b1;
                     state   <= hex_dump_pkg::tx_start_bit;
                  end else begin
                     done    <= byte_last;   // end of dump
                     low_nib <= 1'b0;
                     state   <= in.valid ? hex_dump_pkg::tx_start_bit : hex_dump_pkg::tx_idle;
                  end
               end
            end
            default: state <= hex_dump_pkg::tx_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (load && in.valid) begin
         char_sreg  <= hex_dump_pkg::hex_char(in.data[7:4]);
         low_nibble <= in.data[3:0];
         byte_last  <= in.last;
      end else if (char_end && !low_nib) begin
         char_sreg <= hex_dump_pkg::hex_char(low_nibble);
      end else if (state == hex_dump_pkg::tx_data_bits && bit_end) begin
         char_sreg <= {1'b0, char_sreg[7:1]};
      end
   end

endmodule
